//--- rtl/tv_pkg.sv
// tv framebuffer shared types
`default_nettype none

package tv_pkg;

   // --------------------------------------------------
   // address map
   // --------------------------------------------------

   // one 22-bit word address, read as a framebuffer page
   // or as the register block base
   typedef union packed {
      struct packed {
         logic [6:0]  page;
         logic [14:0] offset;
      } fb;
      struct packed {
         logic [18:0] base;
         logic [2:0]  index;
      } regs;
   } xbus_addr_u;

   // framebuffer page, 17000000 octal
   localparam logic [6:0]  fb_page  = 7'(22'o17000000 >> 15);
   // register block, 17377760 octal
   localparam logic [18:0] reg_base = 19'(22'o17377760 >> 3);

   // register 0 bit positions
   localparam int int_en_bit   = 3;
   localparam int int_flag_bit = 4;

   // one frame at 60 Hz from a 50 MHz clock
   localparam logic [19:0] frame_period = 20'd833333;

   // --------------------------------------------------
   // bus and memory records
   // --------------------------------------------------

   // master side, held until ack
   typedef struct packed {
      xbus_addr_u  addr;
      logic [31:0] wdata;
      logic        write;
      logic        req;
   } xbus_req_t;

   // video memory command
   typedef struct packed {
      logic [14:0] addr;
      logic [31:0] wdata;
      logic        write;   // one-cycle pulse
      logic        req;     // read level, held until ready
   } vram_cmd_t;

   // page hits from decode
   typedef struct packed {
      logic fb;
      logic regs;
   } hit_t;

   typedef enum logic [2:0] {
      st_idle,
      st_write,
      st_read,
      st_reg,
      st_done
   } fb_state_e;

endpackage

`default_nettype wire

//--- rtl/frame_timer.sv
// frame period timer
`default_nettype none

module frame_timer #(
   parameter logic [19:0] period = tv_pkg::frame_period
) (
   input  wire  clk,
   input  wire  reset,
   output logic tick
);

   localparam logic [19:0] last = period - 20'd1;

   logic [19:0] count;

   // --------------------------------------------------
   // free running divider
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (count == last)
         count <= '0;
      else
         count <= count + 20'd1;
   end

   // one cycle per wrap, first one period after reset
   assign tick = count == last;

   a_count_range: assert property (@(posedge clk) disable iff (reset)
      count < period)
      else $error("frame counter ran past its period");

endmodule

`default_nettype wire

//--- rtl/tv_regs.sv
// tv decode and interrupt register
`default_nettype none

module tv_regs (
   input  wire               clk,
   input  wire               reset,
   input  tv_pkg::xbus_req_t xbus_req,
   input  wire               reg_wr,
   input  wire               reg_rd,
   input  wire               fill,
   input  wire  [31:0]       vram_rdata,
   input  wire               tick,
   output tv_pkg::hit_t      hit,
   output logic              decode,
   output logic [31:0]       rdata,
   output logic              interrupt
);
   import tv_pkg::*;

   logic        int_en;
   logic        int_flag;
   logic [31:0] reg_word;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------

   // same address word, two views
   always_comb
   begin
      hit.fb   = xbus_req.addr.fb.page == fb_page;
      hit.regs = xbus_req.addr.regs.base == reg_base;
   end

   // color page left undecoded, no logic answers it
   assign decode = hit.fb | hit.regs;

   // --------------------------------------------------
   // interrupt enable and flag
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         int_en   <= 1'b0;
         int_flag <= 1'b0;
      end
      else
      begin
         if (reg_wr)
            int_en <= xbus_req.wdata[int_en_bit];

         // frame tick beats a clear in the same cycle
         if (tick)
            int_flag <= 1'b1;
         else if (reg_wr && xbus_req.wdata[int_flag_bit])
            int_flag <= 1'b0;
      end
   end

   assign interrupt = int_en & int_flag;

   // --------------------------------------------------
   // read data latch
   // --------------------------------------------------

   // register 0 image, other bits zero
   always_comb
   begin
      reg_word               = '0;
      reg_word[int_en_bit]   = int_en;
      reg_word[int_flag_bit] = int_flag;
   end

   // loaded on the edge that enters done, so valid with ack
   always_ff @(posedge clk)
   begin
      if (reg_rd)
         rdata <= reg_word;
      else if (fill)
         rdata <= vram_rdata;
   end

   // interrupt only rises out of a tick or a register write
   a_int_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(interrupt) |-> int_en && $past(tick || reg_wr))
      else $error("interrupt rose without enable or cause");

endmodule

`default_nettype wire

//--- rtl/fb_ctrl.sv
// tv access state machine
`default_nettype none

module fb_ctrl (
   input  wire               clk,
   input  wire               reset,
   input  tv_pkg::xbus_req_t xbus_req,
   input  tv_pkg::hit_t      hit,
   input  wire               vram_ready,
   output logic              ack,
   output logic              reg_wr,
   output logic              reg_rd,
   output logic              fill,
   output tv_pkg::vram_cmd_t vram_cmd
);
   import tv_pkg::*;

   fb_state_e state;
   fb_state_e state_next;

   // --------------------------------------------------
   // state machine
   // --------------------------------------------------

   always_comb
   begin
      state_next = state;
      case (state)
         st_idle:
            if (xbus_req.req && hit.fb)
               state_next = xbus_req.write ? st_write : st_read;
            else if (xbus_req.req && hit.regs)
               state_next = st_reg;
         // write and register access take one cycle
         st_write: state_next = st_done;
         st_reg:   state_next = st_done;
         // wait out the memory latency
         st_read:
            if (vram_ready)
               state_next = st_done;
         // hold ack until the master lets go
         st_done:
            if (!xbus_req.req)
               state_next = st_idle;
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_next;
   end

   // --------------------------------------------------
   // outputs
   // --------------------------------------------------

   assign ack    = state == st_done;
   assign reg_wr = (state == st_reg) && xbus_req.write;
   assign reg_rd = (state == st_reg) && !xbus_req.write;
   // read data is taken on the read to done edge
   assign fill   = (state == st_read) && vram_ready;

   assign vram_cmd.addr  = xbus_req.addr.fb.offset;
   assign vram_cmd.wdata = xbus_req.wdata;
   assign vram_cmd.write = state == st_write;
   assign vram_cmd.req   = state == st_read;

   a_cmd_excl: assert property (@(posedge clk) disable iff (reset)
      !(vram_cmd.write && vram_cmd.req))
      else $error("write and read together in %s", state.name());

   // ack drops only once the master has released req
   a_ack_fall: assert property (@(posedge clk) disable iff (reset)
      $fell(ack) |-> $past(!xbus_req.req))
      else $error("ack fell while req was held");

endmodule

`default_nettype wire

//--- rtl/xbus_tv.sv
// tv framebuffer bus slave
`default_nettype none

module xbus_tv #(
   parameter logic [19:0] period = tv_pkg::frame_period
) (
   input  wire               clk,
   input  wire               reset,
   input  tv_pkg::xbus_req_t xbus_req,
   input  wire  [31:0]       vram_rdata,
   input  wire               vram_ready,
   output logic [31:0]       rdata,
   output logic              ack,
   output logic              decode,
   output logic              interrupt,
   output tv_pkg::vram_cmd_t vram_cmd
);
   import tv_pkg::*;

   // --------------------------------------------------
   // internal links
   // --------------------------------------------------

   hit_t hit;
   logic reg_wr;
   logic reg_rd;
   logic fill;
   logic tick;

   // decode, interrupt register and read latch
   tv_regs u_tv_regs (
      .clk        (clk),
      .reset      (reset),
      .xbus_req   (xbus_req),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .fill       (fill),
      .vram_rdata (vram_rdata),
      .tick       (tick),
      .hit        (hit),
      .decode     (decode),
      .rdata      (rdata),
      .interrupt  (interrupt)
   );

   // access sequencing and memory command
   fb_ctrl u_fb_ctrl (
      .clk        (clk),
      .reset      (reset),
      .xbus_req   (xbus_req),
      .hit        (hit),
      .vram_ready (vram_ready),
      .ack        (ack),
      .reg_wr     (reg_wr),
      .reg_rd     (reg_rd),
      .fill       (fill),
      .vram_cmd   (vram_cmd)
   );

   // sets the interrupt flag once per frame
   frame_timer #(
      .period (period)
   ) u_frame_timer (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

endmodule

`default_nettype wire

//--- test/vram_model.sv
// behavioral video memory
`default_nettype none

module vram_model (
   input  wire               clk,
   input  wire               reset,
   input  tv_pkg::vram_cmd_t vram_cmd,
   output logic [31:0]       rdata = '0,
   output logic              ready = 1'b0
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] mem [0:32767] = '{default: 32'h0};
   logic        busy;
   logic [1:0]  wait_cnt;
   integer      seed = 32'hf009;

   // writes land on the pulse, reads answer after 1 to 3 cycles
   always @(posedge clk)
   begin
      ready <= 1'b0;
      if (reset)
         busy <= 1'b0;
      else
      begin
         if (vram_cmd.write)
            mem[vram_cmd.addr] <= vram_cmd.wdata;
         if (busy)
         begin
            if (wait_cnt == 2'd0)
            begin
               rdata <= mem[vram_cmd.addr];
               ready <= 1'b1;
               busy  <= 1'b0;
            end
            else
               wait_cnt <= wait_cnt - 2'd1;
         end
         // req still high on the ready edge, not a new read
         else if (vram_cmd.req && !ready)
         begin
            busy     <= 1'b1;
            wait_cnt <= 2'($unsigned($random(seed)) % 3);
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_xbus_tv.sv
// tv framebuffer slave testbench
`default_nettype none

module tb_xbus_tv;
   timeunit 1ns;
   timeprecision 1ps;
   import tv_pkg::*;

   localparam int          num_tests     = 16;
   localparam int          period_cycles = 300;
   localparam int          timeout       = num_tests * 40 + 4 * period_cycles;
   localparam logic [21:0] fb_base       = 22'o17000000;
   localparam logic [21:0] reg_addr      = 22'o17377760;
   localparam logic [3:0]  hold_rand     = 4'hf;

   // --------------------------------------------------
   // stimulus table
   // --------------------------------------------------

   typedef struct packed {
      logic [95:0] name;
      logic        write;
      logic [21:0] addr;
      logic [31:0] wdata;
      logic        decode;
      logic [31:0] rdata;
      logic [3:0]  hold;   // hold_rand draws 0 to 5
   } entry_t;

   // reg entries first, well before the first frame tick
   entry_t tests [num_tests] = '{
      '{"reg_en_on",  1'b1, reg_addr, 32'h0000_0018, 1'b1, 32'h0, 4'd0},
      '{"reg_rd_en",  1'b0, reg_addr, 32'h0, 1'b1, 32'h0000_0008, hold_rand},
      '{"reg_en_off", 1'b1, reg_addr, 32'h0000_0010, 1'b1, 32'h0, 4'd2},
      '{"reg_rd_off", 1'b0, reg_addr, 32'h0, 1'b1, 32'h0, 4'd0},
      '{"fb_wr_a",    1'b1, fb_base + 22'h0010, 32'hdead_beef, 1'b1, 32'h0, 4'd1},
      '{"fb_wr_b",    1'b1, fb_base + 22'h1234, 32'h1234_5678, 1'b1, 32'h0, hold_rand},
      '{"fb_wr_c",    1'b1, fb_base + 22'h7fff, 32'ha5a5_5a5a, 1'b1, 32'h0, 4'd0},
      '{"fb_rd_a",    1'b0, fb_base + 22'h0010, 32'h0, 1'b1, 32'hdead_beef, hold_rand},
      '{"fb_rd_b",    1'b0, fb_base + 22'h1234, 32'h0, 1'b1, 32'h1234_5678, hold_rand},
      '{"fb_rd_c",    1'b0, fb_base + 22'h7fff, 32'h0, 1'b1, 32'ha5a5_5a5a, 4'd3},
      '{"fb_rd_none", 1'b0, fb_base + 22'h0020, 32'h0, 1'b1, 32'h0, hold_rand},
      '{"fb_wr_a2",   1'b1, fb_base + 22'h0010, 32'h0bad_f00d, 1'b1, 32'h0, 4'd5},
      '{"fb_rd_a2",   1'b0, fb_base + 22'h0010, 32'h0, 1'b1, 32'h0bad_f00d, hold_rand},
      '{"color_pg",   1'b0, 22'o17200000, 32'h0, 1'b0, 32'h0, 4'd0},
      '{"low_mem",    1'b0, 22'o00001234, 32'h0, 1'b0, 32'h0, 4'd0},
      '{"below_reg",  1'b1, 22'o17377750, 32'h0, 1'b0, 32'h0, 4'd0}
   };

   logic        clk;
   logic        reset = 1'b1;
   xbus_req_t   xbus_req = '0;
   logic [31:0] vram_rdata;
   logic        vram_ready;
   logic [31:0] rdata;
   logic        ack;
   logic        decode;
   logic        interrupt;
   vram_cmd_t   vram_cmd;
   integer      seed = 32'hf009;

   xbus_tv #(
      .period (20'(period_cycles))
   ) u_xbus_tv (
      .clk        (clk),
      .reset      (reset),
      .xbus_req   (xbus_req),
      .vram_rdata (vram_rdata),
      .vram_ready (vram_ready),
      .rdata      (rdata),
      .ack        (ack),
      .decode     (decode),
      .interrupt  (interrupt),
      .vram_cmd   (vram_cmd)
   );

   vram_model u_vram_model (
      .clk      (clk),
      .reset    (reset),
      .vram_cmd (vram_cmd),
      .rdata    (vram_rdata),
      .ready    (vram_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------------------------------------
   // checks and bus master
   // --------------------------------------------------

   task automatic check_value(input logic [95:0] name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("Fail %0s: expected %h, actual %h", name, expected, actual);
         $display("Errors found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // one access, outputs sampled on the falling edge
   task automatic bus_access(input logic [95:0] name, input logic write,
                             input logic [21:0] addr, input logic [31:0] wdata,
                             input logic exp_decode, input logic [31:0] exp_rdata,
                             input logic [3:0] hold);
      int n;
      @(posedge clk);
      xbus_req.addr  <= addr;
      xbus_req.wdata <= wdata;
      xbus_req.write <= write;
      xbus_req.req   <= 1'b0;
      @(negedge clk);
      check_value(name, {31'd0, exp_decode}, {31'd0, decode});
      if (!exp_decode)
      begin
         // no req for an undecoded address, slave stays quiet
         repeat (10)
         begin
            @(negedge clk);
            check_value(name, 32'd0, {31'd0, ack});
         end
      end
      else
      begin
         @(posedge clk);
         xbus_req.req <= 1'b1;
         do @(negedge clk); while (!ack);
         if (!write)
            check_value(name, exp_rdata, rdata);
         n = (hold == hold_rand) ? int'($unsigned($random(seed)) % 6) : int'(hold);
         repeat (n)
         begin
            @(negedge clk);
            check_value(name, 32'd1, {31'd0, ack});
         end
         @(posedge clk);
         xbus_req.req <= 1'b0;
         do @(negedge clk); while (ack);
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial
   begin
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("reset_out", 32'd0,
                  {28'd0, ack, vram_cmd.write, vram_cmd.req, interrupt});

      for (int i = 0; i < num_tests; i++)
         bus_access(tests[i].name, tests[i].write, tests[i].addr, tests[i].wdata,
                    tests[i].decode, tests[i].rdata, tests[i].hold);

      // enable set, then more than one frame period
      bus_access("int_en_on", 1'b1, reg_addr, 32'h18, 1'b1, 32'h0, 4'd0);
      repeat (period_cycles + 10) @(negedge clk);
      bus_access("int_set_rd", 1'b0, reg_addr, 32'h0, 1'b1, 32'h18, 4'd0);
      check_value("int_high", 32'd1, {31'd0, interrupt});

      // clear the flag, enable kept
      bus_access("int_clear", 1'b1, reg_addr, 32'h18, 1'b1, 32'h0, 4'd0);
      check_value("int_low", 32'd0, {31'd0, interrupt});
      bus_access("int_clr_rd", 1'b0, reg_addr, 32'h0, 1'b1, 32'h08, 4'd0);

      // masked: flag still sets, output stays low
      bus_access("int_en_off", 1'b1, reg_addr, 32'h10, 1'b1, 32'h0, 4'd0);
      repeat (period_cycles + 10)
      begin
         @(negedge clk);
         check_value("int_masked", 32'd0, {31'd0, interrupt});
      end
      bus_access("int_mask_rd", 1'b0, reg_addr, 32'h0, 1'b1, 32'h10, 4'd0);

      $display("No errors");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (timeout + 5) @(posedge clk);
      $display("run timed out waiting for ack");
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

//--- sources.f
rtl/tv_pkg.sv
rtl/frame_timer.sv
rtl/tv_regs.sv
rtl/fb_ctrl.sv
rtl/xbus_tv.sv
test/vram_model.sv
test/tb_xbus_tv.sv

//--- Makefile
# Verilator build and run for the tv framebuffer slave

VERILATOR ?= verilator
TOP       ?= tb_xbus_tv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
